// ==== hw/scu_apb_decoder.sv ====
`timescale 1ns/10ps
module scu_apb_decoder (
  input  logic                                clk_cru_i,
  input  logic                                rst_n_i,
  // APB slave
  input  logic [scu_bus_pkg::AWIDTH-1:0]      paddr_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [scu_bus_pkg::DWIDTH-1:0]      pwdata_i,
  input  logic [scu_bus_pkg::DWIDTH/8-1:0]    pstrb_i,
  output logic [scu_bus_pkg::DWIDTH-1:0]      prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  // Window targets
  output scu_bus_pkg::scu_req_t               reg_req_o,
  output scu_bus_pkg::scu_req_t               pad_req_o,
  input  scu_bus_pkg::scu_rsp_t               reg_rsp_i,
  input  scu_bus_pkg::scu_rsp_t               pad_rsp_i
);

  typedef enum logic {ST_IDLE, ST_RESP} state_e;

  state_e                          state_q;
  logic                            sel_reg;
  logic                            sel_pad;
  logic                            access;
  logic [scu_bus_pkg::DWIDTH-1:0]  rdata_q;
  logic                            err_q;

  // Window decode
  assign sel_reg = paddr_i < scu_bus_pkg::PAD_BASE;
  assign sel_pad = (paddr_i >= scu_bus_pkg::PAD_BASE) && (paddr_i < scu_bus_pkg::PAD_END);

  assign access = psel_i & penable_i & (state_q == ST_IDLE);  // First access cycle only

  always_comb begin
    reg_req_o        = '0;
    pad_req_o        = '0;
    reg_req_o.offset = paddr_i;
    pad_req_o.offset = paddr_i - scu_bus_pkg::PAD_BASE;
    reg_req_o.wdata  = pwdata_i;
    pad_req_o.wdata  = pwdata_i;
    reg_req_o.strb   = pstrb_i;
    pad_req_o.strb   = pstrb_i;
    reg_req_o.rd_en  = access & sel_reg & ~pwrite_i;
    reg_req_o.wr_en  = access & sel_reg & pwrite_i;
    pad_req_o.rd_en  = access & sel_pad & ~pwrite_i;
    pad_req_o.wr_en  = access & sel_pad & pwrite_i;
  end

  // ************************************************************
  // Access tracker, one wait state per transfer
  // ************************************************************
  always_ff @(posedge clk_cru_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (access) begin
      state_q <= ST_RESP;
      if (sel_reg) begin
        rdata_q <= reg_rsp_i.rdata;
        err_q   <= reg_rsp_i.err;
      end else if (sel_pad) begin
        rdata_q <= pad_rsp_i.rdata;
        err_q   <= pad_rsp_i.err;
      end else begin
        rdata_q <= '0;    // Unmapped
        err_q   <= 1'b1;
      end
    end else begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end
  end

  assign pready_o  = (state_q == ST_RESP);
  assign pslverr_o = err_q;   // Only set during the response cycle
  assign prdata_o  = rdata_q;

endmodule

// ==== hw/scu_bus_pkg.sv ====
package scu_bus_pkg;

  // ************************************************************
  // Bus geometry
  // ************************************************************
  localparam int unsigned AWIDTH = 13;
  localparam int unsigned DWIDTH = 32;

  localparam logic [AWIDTH-1:0] PAD_BASE = 13'h1000;  // Pad window start
  localparam int unsigned       PAD_END  = 32'h2000;  // First unmapped address

  // Request as seen by one register window
  typedef struct packed {
    logic                rd_en;   // One-cycle read strobe
    logic                wr_en;   // One-cycle write strobe
    logic [AWIDTH-1:0]   offset;  // Relative to window base
    logic [DWIDTH-1:0]   wdata;
    logic [DWIDTH/8-1:0] strb;
  } scu_req_t;

  // Window reply, valid while a strobe is up
  typedef struct packed {
    logic [DWIDTH-1:0] rdata;
    logic              err;
  } scu_rsp_t;

  // Byte lane merge for partial writes
  function automatic logic [DWIDTH-1:0] strb_merge(
    input logic [DWIDTH-1:0]   old_word,
    input logic [DWIDTH-1:0]   new_word,
    input logic [DWIDTH/8-1:0] strb
  );
    logic [DWIDTH-1:0] res;
    res = old_word;
    for (int b = 0; b < DWIDTH / 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// ==== hw/scu_irq_router.sv ====
`timescale 1ns/10ps
module scu_irq_router #(
  parameter int unsigned NUM_IRQ = 16
) (
  input  logic                                    clk_cru_i,
  input  logic                                    rst_n_i,
  input  logic [NUM_IRQ-1:0]                      irq_src_i,
  input  logic [NUM_IRQ-1:0]                      irq_mask_i,
  input  scu_reg_pkg::irq_route_t [NUM_IRQ-1:0]   irq_map_i,
  output logic [NUM_IRQ-1:0]                      acpu_irq_o,
  output logic [NUM_IRQ-1:0]                      bcpu_irq_o
);

  logic [NUM_IRQ-1:0] enabled;
  logic [NUM_IRQ-1:0] acpu_d;
  logic [NUM_IRQ-1:0] bcpu_d;
  logic [NUM_IRQ-1:0] acpu_q;
  logic [NUM_IRQ-1:0] bcpu_q;

  assign enabled = irq_src_i & irq_mask_i;  // Mask bit 1 lets the source through

  // ************************************************************
  // Routing
  // ************************************************************
  always_comb begin
    for (int i = 0; i < NUM_IRQ; i++) begin
      acpu_d[i] = enabled[i] & irq_map_i[i].acpu;
      bcpu_d[i] = enabled[i] & irq_map_i[i].bcpu;   // Both may be set
    end
  end

  // One register stage before the CPUs
  always_ff @(posedge clk_cru_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acpu_q <= '0;
      bcpu_q <= '0;
    end else begin
      acpu_q <= acpu_d;
      bcpu_q <= bcpu_d;
    end
  end

  assign acpu_irq_o = acpu_q;
  assign bcpu_irq_o = bcpu_q;

endmodule

// ==== hw/scu_pad_ctrl.sv ====
`timescale 1ns/10ps
module scu_pad_ctrl #(
  parameter int unsigned NUM_PADS = 32
) (
  input  logic                   clk_cru_i,
  input  logic                   rst_n_i,
  input  scu_bus_pkg::scu_req_t  req_i,
  output scu_bus_pkg::scu_rsp_t  rsp_o,
  input  logic [NUM_PADS-1:0]    pad_in_i,
  input  logic [NUM_PADS-1:0]    periph_out_i,
  input  logic [NUM_PADS-1:0]    periph_oen_i,
  output scu_reg_pkg::pad_cfg_t  pad_o,
  output logic [NUM_PADS-1:0]    periph_in_o
);

  logic [NUM_PADS-1:0] out_q;
  logic [NUM_PADS-1:0] oen_q;
  logic [NUM_PADS-1:0] pull_en_q;
  logic [NUM_PADS-1:0] pull_dir_q;
  logic [NUM_PADS-1:0] mux_q;
  logic [NUM_PADS-1:0] sync1_q;
  logic [NUM_PADS-1:0] sync2_q;
  logic [NUM_PADS-1:0] out_sel;
  logic [NUM_PADS-1:0] oen_sel;

  logic [scu_bus_pkg::DWIDTH-1:0] rd_word;
  logic [scu_bus_pkg::DWIDTH-1:0] wr_word;
  logic                           hit;
  logic                           wr_ok;

  // ************************************************************
  // Register access
  // ************************************************************
  always_comb begin
    hit = 1'b1;
    case (req_i.offset)
      scu_reg_pkg::PAD_OUT:      rd_word = 32'(out_q);
      scu_reg_pkg::PAD_OEN:      rd_word = 32'(oen_q);
      scu_reg_pkg::PAD_PULL_EN:  rd_word = 32'(pull_en_q);
      scu_reg_pkg::PAD_PULL_DIR: rd_word = 32'(pull_dir_q);
      scu_reg_pkg::PAD_IN:       rd_word = 32'(sync2_q);
      scu_reg_pkg::PAD_MUX:      rd_word = 32'(mux_q);
      default: begin
        rd_word = '0;
        hit     = 1'b0;
      end
    endcase
  end

  assign rsp_o.rdata = rd_word;
  assign rsp_o.err   = (req_i.rd_en | req_i.wr_en) &
                       (~hit | (req_i.wr_en & (req_i.offset == scu_reg_pkg::PAD_IN)));

  assign wr_word = scu_bus_pkg::strb_merge(rd_word, req_i.wdata, req_i.strb);
  assign wr_ok   = req_i.wr_en & ~rsp_o.err;

  always_ff @(posedge clk_cru_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q      <= '0;
      oen_q      <= scu_reg_pkg::PAD_OEN_RESET[NUM_PADS-1:0];  // All pads inputs
      pull_en_q  <= '0;
      pull_dir_q <= '0;
      mux_q      <= '0;
    end else if (wr_ok) begin
      case (req_i.offset)
        scu_reg_pkg::PAD_OUT:      out_q      <= wr_word[NUM_PADS-1:0];
        scu_reg_pkg::PAD_OEN:      oen_q      <= wr_word[NUM_PADS-1:0];
        scu_reg_pkg::PAD_PULL_EN:  pull_en_q  <= wr_word[NUM_PADS-1:0];
        scu_reg_pkg::PAD_PULL_DIR: pull_dir_q <= wr_word[NUM_PADS-1:0];
        scu_reg_pkg::PAD_MUX:      mux_q      <= wr_word[NUM_PADS-1:0];
        default: ;
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_cru_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_in_i;
      sync2_q <= sync1_q;
    end
  end

  // ************************************************************
  // Pad output mux
  // ************************************************************
  assign out_sel = (mux_q & periph_out_i) | (~mux_q & out_q);
  assign oen_sel = (mux_q & periph_oen_i) | (~mux_q & oen_q);

  assign pad_o.out      = 32'(out_sel);
  assign pad_o.oen      = ~32'(~oen_sel);    // Pads above NUM_PADS stay inputs
  assign pad_o.pull_en  = 32'(pull_en_q);
  assign pad_o.pull_dir = 32'(pull_dir_q);
  assign periph_in_o    = sync2_q;

endmodule

// ==== hw/scu_reg_pkg.sv ====
package scu_reg_pkg;

  // ************************************************************
  // SCU window offsets
  // ************************************************************
  localparam logic [scu_bus_pkg::AWIDTH-1:0] REG_ID       = 'h00;  // Read only
  localparam logic [scu_bus_pkg::AWIDTH-1:0] REG_SW_RST   = 'h04;
  localparam logic [scu_bus_pkg::AWIDTH-1:0] REG_IRQ_MASK = 'h08;
  localparam logic [scu_bus_pkg::AWIDTH-1:0] REG_IRQ_MAP  = 'h0C;

  // ************************************************************
  // Pad window offsets
  // ************************************************************
  localparam logic [scu_bus_pkg::AWIDTH-1:0] PAD_OUT      = 'h00;
  localparam logic [scu_bus_pkg::AWIDTH-1:0] PAD_OEN      = 'h04;
  localparam logic [scu_bus_pkg::AWIDTH-1:0] PAD_PULL_EN  = 'h08;
  localparam logic [scu_bus_pkg::AWIDTH-1:0] PAD_PULL_DIR = 'h0C;
  localparam logic [scu_bus_pkg::AWIDTH-1:0] PAD_IN       = 'h10;  // Read only
  localparam logic [scu_bus_pkg::AWIDTH-1:0] PAD_MUX      = 'h14;

  // Software resets, all active low, per in bit 8 down to bcpu in bit 0
  typedef struct packed {
    logic per;
    logic usb;
    logic ddr;
    logic dma;
    logic emac;
    logic fpga0;
    logic fpga1;
    logic acpu;
    logic bcpu;
  } sw_rst_t;

  // Every block held in reset until software releases it
  localparam sw_rst_t SW_RST_RESET = '0;

  // Per-source interrupt route
  typedef struct packed {
    logic bcpu;  // Bit 1
    logic acpu;  // Bit 0
  } irq_route_t;

  // Pad control bundle
  typedef struct packed {
    logic [31:0] out;
    logic [31:0] oen;       // 1 = pad is an input
    logic [31:0] pull_en;
    logic [31:0] pull_dir;
  } pad_cfg_t;

  localparam logic [31:0] PAD_OEN_RESET = '1;

endpackage

// ==== hw/scu_registers.sv ====
`timescale 1ns/10ps
module scu_registers #(
  parameter int unsigned NUM_IRQ = 16
) (
  input  logic                                    clk_cru_i,
  input  logic                                    rst_n_i,
  input  scu_bus_pkg::scu_req_t                   req_i,
  output scu_bus_pkg::scu_rsp_t                   rsp_o,
  // Identification
  input  logic [15:0]                             vendor_id_i,
  input  logic [7:0]                              chip_id_i,
  input  logic [7:0]                              rev_id_i,
  // Controls
  output scu_reg_pkg::sw_rst_t                    sw_rst_o,
  output logic [NUM_IRQ-1:0]                      irq_mask_o,
  output scu_reg_pkg::irq_route_t [NUM_IRQ-1:0]   irq_map_o
);

  localparam int unsigned RST_W = $bits(scu_reg_pkg::sw_rst_t);
  localparam int unsigned MAP_W = 2 * NUM_IRQ;

  scu_reg_pkg::sw_rst_t                    sw_rst_q;
  logic [NUM_IRQ-1:0]                      irq_mask_q;
  scu_reg_pkg::irq_route_t [NUM_IRQ-1:0]   irq_map_q;

  logic [scu_bus_pkg::DWIDTH-1:0]  rd_word;
  logic [scu_bus_pkg::DWIDTH-1:0]  wr_word;
  logic                            hit;
  logic                            read_only;
  logic                            wr_ok;

  // ************************************************************
  // Read mux and access check
  // ************************************************************
  always_comb begin
    rd_word   = '0;
    hit       = 1'b1;
    read_only = 1'b0;
    case (req_i.offset)
      scu_reg_pkg::REG_ID: begin
        rd_word   = {vendor_id_i, chip_id_i, rev_id_i};
        read_only = 1'b1;
      end
      scu_reg_pkg::REG_SW_RST:   rd_word = 32'(sw_rst_q);
      scu_reg_pkg::REG_IRQ_MASK: rd_word = 32'(irq_mask_q);
      scu_reg_pkg::REG_IRQ_MAP:  rd_word = 32'(irq_map_q);
      default:                   hit     = 1'b0;
    endcase
  end

  assign rsp_o.rdata = rd_word;
  assign rsp_o.err   = (req_i.rd_en | req_i.wr_en) & (~hit | (req_i.wr_en & read_only));

  // Byte lanes not strobed keep the current value
  assign wr_word = scu_bus_pkg::strb_merge(rd_word, req_i.wdata, req_i.strb);
  assign wr_ok   = req_i.wr_en & ~rsp_o.err;

  // ************************************************************
  // Writable registers
  // ************************************************************
  always_ff @(posedge clk_cru_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sw_rst_q   <= scu_reg_pkg::SW_RST_RESET;
      irq_mask_q <= '0;   // Everything masked
      irq_map_q  <= '0;
    end else if (wr_ok) begin
      case (req_i.offset)
        scu_reg_pkg::REG_SW_RST:   sw_rst_q   <= scu_reg_pkg::sw_rst_t'(wr_word[RST_W-1:0]);
        scu_reg_pkg::REG_IRQ_MASK: irq_mask_q <= wr_word[NUM_IRQ-1:0];
        scu_reg_pkg::REG_IRQ_MAP:  irq_map_q  <= wr_word[MAP_W-1:0];
        default: ;
      endcase
    end
  end

  // Reset bits go straight out, no sequencing
  assign sw_rst_o   = sw_rst_q;
  assign irq_mask_o = irq_mask_q;
  assign irq_map_o  = irq_map_q;

endmodule

// ==== hw/soc_scu.sv ====
`timescale 1ns/10ps
module soc_scu #(
  parameter int unsigned NUM_IRQ  = 16,
  parameter int unsigned NUM_PADS = 32
) (
  input  logic                                  clk_cru_i,
  input  logic                                  rst_n_i,
  // APB
  input  logic [scu_bus_pkg::AWIDTH-1:0]        paddr_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [scu_bus_pkg::DWIDTH-1:0]        pwdata_i,
  input  logic [scu_bus_pkg::DWIDTH/8-1:0]      pstrb_i,
  output logic [scu_bus_pkg::DWIDTH-1:0]        prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  // ID
  input  logic [15:0]                           vendor_id_i,
  input  logic [7:0]                            chip_id_i,
  input  logic [7:0]                            rev_id_i,
  // Interrupts and resets
  input  logic [NUM_IRQ-1:0]                    irq_src_i,
  output scu_reg_pkg::sw_rst_t                  sw_rst_o,
  output logic [NUM_IRQ-1:0]                    acpu_irq_o,
  output logic [NUM_IRQ-1:0]                    bcpu_irq_o,
  // Pads
  input  logic [NUM_PADS-1:0]                   pad_in_i,
  input  logic [NUM_PADS-1:0]                   periph_out_i,
  input  logic [NUM_PADS-1:0]                   periph_oen_i,
  output scu_reg_pkg::pad_cfg_t                 pad_o,
  output logic [NUM_PADS-1:0]                   periph_in_o
);

  scu_bus_pkg::scu_req_t                   reg_req;
  scu_bus_pkg::scu_req_t                   pad_req;
  scu_bus_pkg::scu_rsp_t                   reg_rsp;
  scu_bus_pkg::scu_rsp_t                   pad_rsp;
  logic [NUM_IRQ-1:0]                      irq_mask;
  scu_reg_pkg::irq_route_t [NUM_IRQ-1:0]   irq_map;

  // ************************************************************
  // Bus side
  // ************************************************************
  scu_apb_decoder scu_apb_decoder_inst (
    .clk_cru_i(clk_cru_i), .rst_n_i(rst_n_i),
    .paddr_i  (paddr_i  ), .psel_i   (psel_i   ), .penable_i(penable_i),
    .pwrite_i (pwrite_i ), .pwdata_i (pwdata_i ), .pstrb_i  (pstrb_i  ),
    .prdata_o (prdata_o ), .pready_o (pready_o ), .pslverr_o(pslverr_o),
    .reg_req_o(reg_req  ), .pad_req_o(pad_req  ),
    .reg_rsp_i(reg_rsp  ), .pad_rsp_i(pad_rsp  )
  );

  scu_registers #(.NUM_IRQ(NUM_IRQ)) scu_registers_inst (
    .clk_cru_i  (clk_cru_i  ), .rst_n_i  (rst_n_i  ),
    .req_i      (reg_req    ), .rsp_o    (reg_rsp  ),
    .vendor_id_i(vendor_id_i), .chip_id_i(chip_id_i), .rev_id_i(rev_id_i),
    .sw_rst_o   (sw_rst_o   ), .irq_mask_o(irq_mask), .irq_map_o(irq_map)
  );

  // ************************************************************
  // Datapath blocks
  // ************************************************************
  scu_irq_router #(.NUM_IRQ(NUM_IRQ)) scu_irq_router_inst (
    .clk_cru_i (clk_cru_i ), .rst_n_i   (rst_n_i   ),
    .irq_src_i (irq_src_i ), .irq_mask_i(irq_mask  ), .irq_map_i(irq_map),
    .acpu_irq_o(acpu_irq_o), .bcpu_irq_o(bcpu_irq_o)
  );

  scu_pad_ctrl #(.NUM_PADS(NUM_PADS)) scu_pad_ctrl_inst (
    .clk_cru_i   (clk_cru_i   ), .rst_n_i     (rst_n_i     ),
    .req_i       (pad_req     ), .rsp_o       (pad_rsp     ),
    .pad_in_i    (pad_in_i    ), .periph_out_i(periph_out_i),
    .periph_oen_i(periph_oen_i), .pad_o       (pad_o       ),
    .periph_in_o (periph_in_o )
  );

endmodule

// ==== soc_scu.f ====
hw/scu_bus_pkg.sv
hw/scu_reg_pkg.sv
hw/scu_apb_decoder.sv
hw/scu_registers.sv
hw/scu_irq_router.sv
hw/scu_pad_ctrl.sv
hw/soc_scu.sv
test/soc_scu_tb.sv

// ==== test/soc_scu_tb.sv ====
`timescale 1ns/10ps
module soc_scu_tb;

  localparam int unsigned NUM_IRQ        = 16;
  localparam int unsigned NUM_PADS       = 32;
  localparam int unsigned TIMEOUT_CYCLES = 2000;  // About four times the test length

  localparam logic [12:0] A_ID       = scu_reg_pkg::REG_ID;
  localparam logic [12:0] A_SW_RST   = scu_reg_pkg::REG_SW_RST;
  localparam logic [12:0] A_UNUSED   = 13'h010;   // No SCU register here
  localparam logic [12:0] A_PAD_OUT  = scu_bus_pkg::PAD_BASE + scu_reg_pkg::PAD_OUT;
  localparam logic [12:0] A_PAD_OEN  = scu_bus_pkg::PAD_BASE + scu_reg_pkg::PAD_OEN;
  localparam logic [12:0] A_PAD_IN   = scu_bus_pkg::PAD_BASE + scu_reg_pkg::PAD_IN;
  localparam logic [12:0] A_PAD_MUX  = scu_bus_pkg::PAD_BASE + scu_reg_pkg::PAD_MUX;
  // 13-bit bus ends at 0x1FFF, top word of the pad window holds no register
  localparam logic [12:0] A_TOP      = 13'h1FFC;

  logic                  clk_cru = 1'b0;
  logic                  rst_n;
  logic [12:0]           paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [31:0]           pwdata;
  logic [3:0]            pstrb;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  logic [15:0]           vendor_id;
  logic [7:0]            chip_id;
  logic [7:0]            rev_id;
  logic [NUM_IRQ-1:0]    irq_src;
  logic [NUM_IRQ-1:0]    acpu_irq;
  logic [NUM_IRQ-1:0]    bcpu_irq;
  scu_reg_pkg::sw_rst_t  sw_rst;
  logic [NUM_PADS-1:0]   pad_in;
  logic [NUM_PADS-1:0]   periph_out;
  logic [NUM_PADS-1:0]   periph_oen;
  logic [NUM_PADS-1:0]   periph_in;
  scu_reg_pkg::pad_cfg_t pad_cfg;

  // Shadow model: 0 irq mask, 1 irq map, 2 pull enable, 3 pull direction
  logic [12:0]          rw_addr   [4];
  logic [31:0]          rw_width  [4];
  logic [31:0]          rw_shadow [4];
  logic [8:0]           rst_shadow;
  logic                 route_chk = 1'b0;
  logic [NUM_IRQ-1:0]   exp_acpu;
  logic [NUM_IRQ-1:0]   exp_bcpu;
  int unsigned          cycles = 0;

  always #2 clk_cru = ~clk_cru;

  soc_scu #(.NUM_IRQ(NUM_IRQ), .NUM_PADS(NUM_PADS)) soc_scu_inst (
    .clk_cru_i   (clk_cru   ), .rst_n_i     (rst_n     ),
    .paddr_i     (paddr     ), .psel_i      (psel      ), .penable_i(penable),
    .pwrite_i    (pwrite    ), .pwdata_i    (pwdata    ), .pstrb_i  (pstrb  ),
    .prdata_o    (prdata    ), .pready_o    (pready    ), .pslverr_o(pslverr),
    .vendor_id_i (vendor_id ), .chip_id_i   (chip_id   ), .rev_id_i (rev_id ),
    .irq_src_i   (irq_src   ), .sw_rst_o    (sw_rst    ),
    .acpu_irq_o  (acpu_irq  ), .bcpu_irq_o  (bcpu_irq  ),
    .pad_in_i    (pad_in    ), .periph_out_i(periph_out), .periph_oen_i(periph_oen),
    .pad_o       (pad_cfg   ), .periph_in_o (periph_in )
  );

  task automatic report_failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] lane_mask;
    lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~lane_mask) | (new_word & lane_mask);
  endfunction

  // Source passes when its mask bit and the CPU's route bit are set
  function automatic logic [NUM_IRQ-1:0] route_to(input logic [NUM_IRQ-1:0] src,
                                                 input logic [31:0] mask,
                                                 input logic [31:0] map,
                                                 input int          cpu);
    logic [NUM_IRQ-1:0] res;
    for (int i = 0; i < NUM_IRQ; i++) begin
      res[i] = src[i] & mask[i] & map[2*i + cpu];
    end
    return res;
  endfunction

  assign exp_acpu = route_to(irq_src, rw_shadow[0], rw_shadow[1], 0);
  assign exp_bcpu = route_to(irq_src, rw_shadow[0], rw_shadow[1], 1);

  // ************************************************************
  // Concurrent checks
  // ************************************************************
  assert property (@(posedge clk_cru) disable iff (!rst_n)
    (psel && !penable) |-> ##1 !pready ##1 pready)
    else report_failure("pready_o not high exactly 2 cycles after setup");
  assert property (@(posedge clk_cru) disable iff (!rst_n) pready |=> !pready)
    else report_failure("pready_o high for more than one cycle");
  assert property (@(posedge clk_cru) disable iff (!rst_n) pslverr |-> pready)
    else report_failure("pslverr_o outside the response cycle");
  assert property (@(posedge clk_cru) disable iff (!rst_n)
    (route_chk && $past(route_chk)) |->
      ((acpu_irq == $past(exp_acpu)) && (bcpu_irq == $past(exp_bcpu))))
    else report_failure($sformatf("irq routing acpu %h bcpu %h", acpu_irq, bcpu_irq));

  // Hang guard
  always @(posedge clk_cru) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

  // ************************************************************
  // APB master
  // ************************************************************
  task automatic bus_transfer(input logic wr, input logic [12:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk_cru);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= data;
    pstrb   <= strb;
    psel    <= 1'b1;
    penable <= 1'b0;   // Setup phase
    @(posedge clk_cru);
    penable <= 1'b1;
    do @(posedge clk_cru); while (!pready);
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [12:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    logic [31:0] unused_rd;
    bus_transfer(1'b1, addr, data, strb, unused_rd, err);
  endtask

  task automatic apb_read(input logic [12:0] addr, output logic [31:0] data, output logic err);
    bus_transfer(1'b0, addr, '0, 4'h0, data, err);
  endtask

  // ************************************************************
  // Behaviors
  // ************************************************************
  task automatic after_reset_state();
    assert (!pready && !pslverr && acpu_irq == '0 && bcpu_irq == '0)
      else report_failure("bus or irq outputs not low after reset");
    assert (sw_rst == '0) else report_failure($sformatf("sw_rst_o %h after reset", sw_rst));
    assert (pad_cfg.oen == '1) else report_failure("pad oen not all ones after reset");
  endtask

  task automatic id_readback();
    logic [31:0] rd;
    logic        err;
    apb_read(A_ID, rd, err);
    assert (!err && rd == {vendor_id, chip_id, rev_id})
      else report_failure($sformatf("REG_ID read %h", rd));
  endtask

  task automatic random_readback(input int n);
    logic [31:0] rd;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        err;
    int unsigned idx;
    for (int k = 0; k < n; k++) begin
      idx   = $urandom_range(3, 0);
      wdata = $urandom();
      strb  = 4'($urandom_range(15, 0));
      apb_write(rw_addr[idx], wdata, strb, err);
      assert (!err) else report_failure($sformatf("write to %h flagged", rw_addr[idx]));
      rw_shadow[idx] = merge_bytes(rw_shadow[idx], wdata, strb) & rw_width[idx];
      apb_read(rw_addr[idx], rd, err);
      assert (!err && rd == rw_shadow[idx])
        else report_failure($sformatf("%h read %h, expected %h", rw_addr[idx], rd,
                                      rw_shadow[idx]));
    end
  endtask

  task automatic sw_reset_outputs();
    logic [31:0] wdata;
    logic [31:0] full;
    logic [3:0]  strb;
    logic        err;
    full = '0;
    for (int k = 0; k < 4; k++) begin
      wdata = $urandom();
      strb  = (k == 0) ? 4'hF : 4'($urandom_range(15, 0));
      apb_write(A_SW_RST, wdata, strb, err);
      full       = merge_bytes(full, wdata, strb);
      rst_shadow = full[8:0];
      assert (!err && sw_rst == rst_shadow)
        else report_failure($sformatf("sw_rst_o %h, expected %h", sw_rst, rst_shadow));
    end
  endtask

  task automatic irq_routing(input int rounds);
    logic [31:0] mask_val;
    logic [31:0] map_val;
    logic        err;
    for (int r = 0; r < rounds; r++) begin
      mask_val = $urandom();
      map_val  = $urandom();
      route_chk <= 1'b0;
      apb_write(scu_reg_pkg::REG_IRQ_MASK, mask_val, 4'hF, err);
      assert (!err) else report_failure("write to REG_IRQ_MASK flagged");
      rw_shadow[0] = mask_val & rw_width[0];
      apb_write(scu_reg_pkg::REG_IRQ_MAP, map_val, 4'hF, err);
      assert (!err) else report_failure("write to REG_IRQ_MAP flagged");
      rw_shadow[1] = map_val & rw_width[1];
      route_chk <= 1'b1;
      repeat (20) begin
        @(posedge clk_cru);
        irq_src <= NUM_IRQ'($urandom());
      end
    end
    route_chk <= 1'b0;
  endtask

  task automatic pad_output_mux(input int n);
    logic [31:0]         out_val;
    logic [31:0]         oen_val;
    logic [31:0]         mux_val;
    logic [NUM_PADS-1:0] exp_out;
    logic [NUM_PADS-1:0] exp_oen;
    logic                err;
    out_val = $urandom();
    oen_val = $urandom();
    mux_val = $urandom();
    apb_write(A_PAD_OUT, out_val, 4'hF, err);
    apb_write(A_PAD_OEN, oen_val, 4'hF, err);
    apb_write(A_PAD_MUX, mux_val, 4'hF, err);
    repeat (n) begin
      @(posedge clk_cru);
      periph_out <= $urandom();
      periph_oen <= $urandom();
      @(posedge clk_cru);
      for (int i = 0; i < NUM_PADS; i++) begin
        exp_out[i] = mux_val[i] ? periph_out[i] : out_val[i];
        exp_oen[i] = mux_val[i] ? periph_oen[i] : oen_val[i];
      end
      assert (pad_cfg.out == exp_out && pad_cfg.oen == exp_oen)
        else report_failure($sformatf("pad out %h oen %h", pad_cfg.out, pad_cfg.oen));
      assert (pad_cfg.pull_en == rw_shadow[2] && pad_cfg.pull_dir == rw_shadow[3])
        else report_failure("pad pull controls differ from the registers");
    end
  endtask

  task automatic pad_input_sync(input int n);
    logic [31:0] rd;
    logic [31:0] value;
    logic        err;
    repeat (n) begin
      value = $urandom();
      @(posedge clk_cru);
      pad_in <= value;
      repeat (3) @(posedge clk_cru);
      assert (periph_in == value) else report_failure($sformatf("periph_in_o %h", periph_in));
      apb_read(A_PAD_IN, rd, err);
      assert (!err && rd == value) else report_failure($sformatf("PAD_IN read %h", rd));
    end
  endtask

  task automatic error_responses();
    logic [31:0] rd;
    logic        err;
    apb_write(A_ID, $urandom(), 4'hF, err);
    assert (err) else report_failure("write to REG_ID was accepted");
    apb_write(A_PAD_IN, $urandom(), 4'hF, err);
    assert (err) else report_failure("write to PAD_IN was accepted");
    apb_write(A_UNUSED, $urandom(), 4'hF, err);
    assert (err) else report_failure("write to an unused SCU offset was accepted");
    apb_read(A_UNUSED, rd, err);
    assert (err) else report_failure("read of an unused SCU offset was accepted");
    apb_write(A_TOP, $urandom(), 4'hF, err);
    assert (err) else report_failure("write to the top pad address was accepted");
    apb_read(A_TOP, rd, err);
    assert (err) else report_failure("read of the top pad address was accepted");
    // Readback after the rejected accesses
    apb_read(A_ID, rd, err);
    assert (!err && rd == {vendor_id, chip_id, rev_id})
      else report_failure($sformatf("REG_ID changed to %h", rd));
    apb_read(A_PAD_IN, rd, err);
    assert (!err && rd == pad_in) else report_failure($sformatf("PAD_IN changed to %h", rd));
    assert (sw_rst == rst_shadow) else report_failure("sw_rst_o changed by a bad access");
    for (int i = 0; i < 4; i++) begin
      apb_read(rw_addr[i], rd, err);
      assert (!err && rd == rw_shadow[i])
        else report_failure($sformatf("%h changed to %h", rw_addr[i], rd));
    end
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************
  initial begin
    void'($urandom(32'h2905));
    rst_n      <= 1'b0;
    paddr      <= '0;
    psel       <= 1'b0;
    penable    <= 1'b0;
    pwrite     <= 1'b0;
    pwdata     <= '0;
    pstrb      <= '0;
    vendor_id  <= 16'hA5C3;
    chip_id    <= 8'h42;
    rev_id     <= 8'h07;
    irq_src    <= '0;
    pad_in     <= '0;
    periph_out <= '0;
    periph_oen <= '0;
    rw_addr[0]   = scu_reg_pkg::REG_IRQ_MASK;
    rw_addr[1]   = scu_reg_pkg::REG_IRQ_MAP;
    rw_addr[2]   = scu_bus_pkg::PAD_BASE + scu_reg_pkg::PAD_PULL_EN;
    rw_addr[3]   = scu_bus_pkg::PAD_BASE + scu_reg_pkg::PAD_PULL_DIR;
    rw_width[0]  = 32'((1 << NUM_IRQ) - 1);
    rw_width[1]  = '1;
    rw_width[2]  = '1;
    rw_width[3]  = '1;
    rw_shadow[0] = '0;
    rw_shadow[1] = '0;
    rw_shadow[2] = '0;
    rw_shadow[3] = '0;
    rst_shadow   = '0;
    repeat (2) @(posedge clk_cru);
    rst_n <= 1'b1;
    @(posedge clk_cru);
    after_reset_state();
    id_readback();
    random_readback(40);
    sw_reset_outputs();
    irq_routing(4);
    pad_output_mux(8);
    pad_input_sync(3);
    error_responses();
    $display("Everything OK");
    $finish;
  end

endmodule
